// ==== compile.f ====
+incdir+.
decode_pkg.sv
decode_stage_reg.sv
imm_gen.sv
ctrl_decode.sv
reg_file.sv
csr_file.sv
idu_top.sv
tb_idu.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_idu
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_idu_ref.svh ====
`ifndef TB_IDU_REF_SVH
`define TB_IDU_REF_SVH

// immediate straight from the field layout of each format.
function automatic word_t ref_imm(input word_t i);
    logic [11:0] b;
    b = {i[31], i[7], i[30:25], i[11:8]};
    case (i[6:0])
        OP_R:                                return {25'd0, i[31:25]};
        OP_LOAD, OP_IMM, OP_JALR, OP_SYSTEM: return {20'd0, i[31:20]};
        OP_LUI, OP_AUIPC:                    return {12'd0, i[31:12]};
        OP_JAL:                              return {12'd0, i[31], i[19:12], i[20], i[30:21]};
        OP_BRANCH:                           return {{20{b[11]}}, b} << 1;
        OP_STORE:                            return {20'd0, i[31:25], i[11:7]};
        default:                             return '0;
    endcase
endfunction

function automatic ctrl_t ref_ctrl(input word_t i);
    ctrl_t       c;
    logic [2:0]  f3;
    logic [6:0]  op;
    word_t       imm;
    logic [31:0] alu_tbl;
    f3      = i[14:12];
    op      = i[6:0];
    imm     = ref_imm(i);
    alu_tbl = {ALU_AND, ALU_OR, ALU_SRL, ALU_XOR, ALU_SLTU, ALU_SLT, ALU_SLL, ALU_ADD};
    c       = '0;
    c.r_wen   = (op != 7'd0);
    c.ecall   = (i == INST_ECALL);
    c.mret    = (i == INST_MRET);
    c.fence_i = (i == INST_FENCE_I);
    case (op)
        OP_LOAD: c.mem_ren = 1'b1;
        OP_STORE: begin
            c.mem_wen = 1'b1;
            c.r_wen   = 1'b0;
        end
        OP_LUI: begin
            c.add1_sel = SRC1_ZERO;
            c.imm_kind = IMM_20U;
        end
        OP_AUIPC: begin
            c.add1_sel = SRC1_PC;
            c.imm_kind = IMM_20U;
        end
        OP_JAL: begin
            c.jump     = 1'b1;
            c.add1_sel = SRC1_PC;
            c.imm_kind = IMM_20J;
        end
        OP_JALR: c.jump = 1'b1;
        OP_BRANCH: begin
            c.branch   = 1'b1;
            c.r_wen    = 1'b0;
            c.add2_sel = SRC2_REG;
            c.inv      = (f3 == 3'b000) || (f3 == 3'b101) || (f3 == 3'b111);
            if (!f3[2]) c.alu_op = f3[1] ? ALU_ADD : ALU_EQ;
            else c.alu_op = f3[1] ? ALU_SLTU : ALU_SLT;
        end
        OP_R, OP_IMM: begin
            c.alu_op = alu_tbl[{f3, 2'b00} +: 4];
            if (i[31:25] != 7'd0 && f3 == 3'b101) c.alu_op = ALU_SRA;
            if (i[31:25] != 7'd0 && f3 == 3'b000 && op == OP_R) c.alu_op = ALU_SUB;
            if (op == OP_R) c.add2_sel = SRC2_REG;
            else if (f3[1:0] == 2'b01) c.imm_kind = IMM_5U; // shift amount.
        end
        OP_SYSTEM: begin
            c.csr_wen = {imm == {20'd0, CSR_MTVEC}, imm == {20'd0, CSR_MSTATUS},
                         imm == {20'd0, CSR_MCAUSE}, imm == {20'd0, CSR_MEPC}};
            if (f3 == 3'b010) begin
                c.add2_sel = SRC2_CSR_OR;
                c.alu_op   = ALU_OR;
            end else if (f3 == 3'b001) begin
                c.add2_sel = SRC2_CSR_WR;
            end
        end
        default: c.alu_op = ALU_ADD;
    endcase
    return c;
endfunction

`endif

// ==== tb_idu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_idu;
    import decode_pkg::*;

    `include "tb_idu_ref.svh"

    localparam int N_DECODE    = 400;
    localparam int N_ITEMS     = 440; // decode plus directed items with slack.
    localparam int WATCHDOG_NS = (N_ITEMS * 20 + 200) * 10;

    logic       clock = 1'b0;
    logic       reset;
    logic       valid_last;
    logic       ready_next;
    logic       inst_clear;
    word_t      inst;
    word_t      pc;
    rf_write_t  rf_wr;
    csr_write_t csr_wr;
    logic       ready_last;
    logic       valid_next;
    decoded_t   dec;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      rs1_value;
    word_t      rs2_value;
    word_t      csrs;
    word_t      mepc_out;
    word_t      mtvec_out;

    integer      seed;
    logic        bp;
    word_t       next_pc;
    logic [63:0] sb [$]; // {inst, pc} per unflushed accept.
    word_t       rf_model [32];
    word_t       m_mstatus, m_mtvec, m_mepc, m_mcause;
    logic        pend;
    logic        stalled;
    word_t       held_inst, held_pc;
    int          n_out;

    idu_top uut (.*);

    always #5 clock = ~clock;

    task automatic abort(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            abort("check mismatch");
        end
    endtask

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    // offer one instruction and hold it until taken.
    task automatic issue(input word_t i, input logic clr);
        logic   taken;
        integer rnd;
        valid_last = 1'b1;
        inst       = i;
        pc         = next_pc;
        inst_clear = clr;
        taken      = 1'b0;
        while (!taken) begin
            taken = ready_next;
            step();
            inst_clear = 1'b0;
            rnd        = $random(seed);
            if (bp) ready_next = rnd[0];
        end
        valid_last = 1'b0;
        next_pc    = next_pc + 32'd4;
    endtask

    task automatic rf_write(input reg_addr_t a, input word_t d);
        rf_wr = '{wen: 1'b1, addr: a, data: d};
        step();
        rf_wr = '0;
    endtask

    task automatic csr_write(input csr_mask_t m, input word_t d);
        csr_wr = '{wen: m, data: d};
        step();
        csr_wr = '0;
    endtask

    task automatic drain();
        ready_next = 1'b1;
        while (sb.size() != 0 || valid_next) step();
    endtask

    function automatic logic [11:0] csr_addr_of(input logic [1:0] k);
        case (k)
            2'd0:    return CSR_MEPC;
            2'd1:    return CSR_MCAUSE;
            2'd2:    return CSR_MSTATUS;
            default: return CSR_MTVEC;
        endcase
    endfunction

    function automatic word_t csr_read(input logic [11:0] a);
        if (a == CSR_MSTATUS) return m_mstatus;
        if (a == CSR_MTVEC) return m_mtvec;
        if (a == CSR_MEPC) return m_mepc;
        if (a == CSR_MCAUSE) return m_mcause;
        return '0;
    endfunction

    function automatic word_t rand_inst();
        word_t w;
        int    sel;
        w   = $random(seed);
        sel = int'($unsigned($random(seed)) % 13);
        case (sel)
            0: w[6:0] = OP_R;
            1: w[6:0] = OP_LOAD;
            2: w[6:0] = OP_IMM;
            3: w[6:0] = OP_JALR;
            4: w[6:0] = OP_LUI;
            5: w[6:0] = OP_AUIPC;
            6: w[6:0] = OP_JAL;
            7: w[6:0] = OP_BRANCH;
            8: w[6:0] = OP_STORE;
            9: begin
                w[6:0] = OP_SYSTEM;
                if (w[7]) w[31:20] = csr_addr_of(w[9:8]); // a real csr half the time.
            end
            10: w = INST_ECALL;
            11: w = INST_MRET;
            default: w = INST_FENCE_I;
        endcase
        return w;
    endfunction

    // compare outputs, then update the models for the coming edge.
    always @(negedge clock) begin : monitor
        logic [63:0] ent;
        word_t       ei;
        word_t       epc;
        logic        trap;
        if (reset) begin
            foreach (rf_model[k]) rf_model[k] = '0;
            m_mstatus = '0;
            m_mtvec   = '0;
            m_mepc    = '0;
            m_mcause  = '0;
            pend      = 1'b0;
            stalled   = 1'b0;
            n_out     = 0;
            sb.delete();
        end else begin
            trap = 1'b0;
            epc  = '0;
            check_value("ready_last", 32'(ready_next), 32'(ready_last));
            check_value("mepc_out", m_mepc, mepc_out);
            check_value("mtvec_out", m_mtvec, mtvec_out);
            if (stalled) begin
                check_value("valid_next", 32'd1, 32'(valid_next));
                check_value("dec.inst", held_inst, dec.inst);
                check_value("dec.pc", held_pc, dec.pc);
            end
            stalled   = valid_next && !ready_next;
            held_inst = dec.inst;
            held_pc   = dec.pc;
            if (valid_next && ready_next) begin
                if (sb.size() == 0) begin
                    abort($sformatf("output at pc %h with nothing expected", dec.pc));
                end else begin
                    ent = sb.pop_front();
                    ei  = ent[63:32];
                    epc = ent[31:0];
                    check_value("dec.inst", ei, dec.inst);
                    check_value("dec.pc", epc, dec.pc);
                    check_value("dec.rd", 32'(ei[11:7]), 32'(dec.rd));
                    check_value("dec.funct3", 32'(ei[14:12]), 32'(dec.funct3));
                    check_value("dec.imm", ref_imm(ei), dec.imm);
                    check_value("dec.ctrl", 32'(ref_ctrl(ei)), 32'(dec.ctrl));
                    check_value("rs1", 32'(ei[19:15]), 32'(rs1));
                    check_value("rs2", 32'(ei[24:20]), 32'(rs2));
                    check_value("rs1_value", rf_model[ei[19:15]], rs1_value);
                    check_value("rs2_value", rf_model[ei[24:20]], rs2_value);
                    check_value("csrs", csr_read(ei[31:20]), csrs);
                    trap  = (ei == INST_ECALL);
                    n_out = n_out + 1;
                end
            end
            if (trap) begin
                m_mepc   = epc;
                m_mcause = MCAUSE_ECALL;
            end else begin
                if (csr_wr.wen[0]) m_mepc = csr_wr.data;
                if (csr_wr.wen[1]) m_mcause = csr_wr.data;
            end
            if (csr_wr.wen[2]) m_mstatus = csr_wr.data;
            if (csr_wr.wen[3]) m_mtvec = csr_wr.data;
            if (rf_wr.wen && rf_wr.addr != 5'd0) rf_model[rf_wr.addr] = rf_wr.data;
            if (valid_last && ready_next) begin
                if (!(inst_clear || pend)) begin
                    sb.push_back({inst, pc});
                end
                pend = 1'b0;
            end else if (inst_clear) begin
                pend = 1'b1; // kills the next accept.
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort($sformatf("timeout, the run did not finish within %0d ns", WATCHDOG_NS));
    end

    initial begin : stimulus
        int        i;
        integer    rnd;
        word_t     ecall_pc;
        reg_addr_t a;
        reg_addr_t prev;
        seed       = 32'hc488_f771;
        reset      = 1'b1;
        valid_last = 1'b0;
        ready_next = 1'b1;
        inst_clear = 1'b0;
        inst       = '0;
        pc         = '0;
        rf_wr      = '0;
        csr_wr     = '0;
        bp         = 1'b0;
        next_pc    = 32'h0000_1000;
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;

        // random decode with back-pressure in the second half.
        for (i = 0; i < N_DECODE; i++) begin
            bp = (i >= N_DECODE / 2);
            issue(rand_inst(), 1'b0);
        end
        bp = 1'b0;
        drain();

        prev = 5'd0;
        for (i = 0; i < 8; i++) begin
            rnd = $random(seed);
            a   = rnd[4:0];
            rf_write(a, $random(seed));
            issue({7'd0, prev, a, 3'b000, 5'd1, OP_R}, 1'b0);
            prev = a;
        end
        rf_write(5'd0, 32'hdead_beef);
        issue({7'd0, 5'd0, 5'd0, 3'b000, 5'd1, OP_R}, 1'b0);
        drain();

        for (i = 0; i < 4; i++) begin
            csr_write(csr_mask_t'(1 << i), $random(seed));
            issue({csr_addr_of(i[1:0]), 5'd0, 3'b010, 5'd2, OP_SYSTEM}, 1'b0);
        end
        drain();

        issue(rand_inst(), 1'b1); // cleared on the accept itself.
        inst_clear = 1'b1;        // idle flush.
        step();
        inst_clear = 1'b0;
        issue(rand_inst(), 1'b0);
        for (i = 0; i < 4; i++) issue(rand_inst(), 1'b0);
        drain();

        ecall_pc = next_pc;
        issue(INST_ECALL, 1'b0);
        issue({CSR_MCAUSE, 5'd0, 3'b010, 5'd3, OP_SYSTEM}, 1'b0);
        issue({CSR_MEPC, 5'd0, 3'b010, 5'd4, OP_SYSTEM}, 1'b0);
        drain();
        check_value("mepc_out", ecall_pc, mepc_out);
        // rf, csr, flush and trap items that survive, the two flushed ones left out.
        check_value("output count", N_DECODE + 9 + 4 + 4 + 3, n_out);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== idu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module idu_top (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    valid_last,
    input  wire                    ready_next,
    input  wire                    inst_clear,
    input  decode_pkg::word_t      inst,
    input  decode_pkg::word_t      pc,
    input  decode_pkg::rf_write_t  rf_wr,
    input  decode_pkg::csr_write_t csr_wr,
    output logic                   ready_last,
    output logic                   valid_next,
    output decode_pkg::decoded_t   dec,
    output decode_pkg::reg_addr_t  rs1,
    output decode_pkg::reg_addr_t  rs2,
    output decode_pkg::word_t      rs1_value,
    output decode_pkg::word_t      rs2_value,
    output decode_pkg::word_t      csrs,
    output decode_pkg::word_t      mepc_out,
    output decode_pkg::word_t      mtvec_out
);
    import decode_pkg::*;

    word_t inst_q;
    word_t pc_q;
    word_t imm;
    ctrl_t ctrl;

    decode_stage_reg u_stage (
        .clock, .reset, .valid_last, .ready_next, .inst_clear, .inst, .pc,
        .ready_last, .valid_next, .inst_q, .pc_q
    );

    imm_gen u_imm (.inst(inst_q), .imm);

    ctrl_decode u_ctrl (.inst(inst_q), .imm, .ctrl);

    assign rs1 = inst_q[19:15];
    assign rs2 = inst_q[24:20];

    reg_file u_rf (.clock, .reset, .rs1, .rs2, .rf_wr, .rs1_value, .rs2_value);

    csr_file u_csr (
        .clock, .reset,
        .pc           (pc_q),
        .csr_addr     (inst_q[31:20]),
        .ecall_commit (valid_next & ready_next & ctrl.ecall), // ecall leaving the stage.
        .csr_wr, .csrs, .mepc_out, .mtvec_out
    );

    assign dec = '{inst: inst_q, pc: pc_q, rd: inst_q[11:7], funct3: inst_q[14:12],
                   imm: imm, ctrl: ctrl};

endmodule

`default_nettype wire

// ==== csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire                    clock,
    input  wire                    reset,
    input  decode_pkg::word_t      pc,
    input  wire  [11:0]            csr_addr,
    input  wire                    ecall_commit,
    input  decode_pkg::csr_write_t csr_wr,
    output decode_pkg::word_t      csrs,
    output decode_pkg::word_t      mepc_out,
    output decode_pkg::word_t      mtvec_out
);
    import decode_pkg::*;

    word_t mstatus;
    word_t mtvec;
    word_t mepc;
    word_t mcause;

    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else begin
            if (ecall_commit) begin // trap entry wins over writeback.
                mepc   <= pc;
                mcause <= MCAUSE_ECALL;
            end else begin
                if (csr_wr.wen[0]) mepc <= csr_wr.data;
                if (csr_wr.wen[1]) mcause <= csr_wr.data;
            end
            if (csr_wr.wen[2]) mstatus <= csr_wr.data;
            if (csr_wr.wen[3]) mtvec <= csr_wr.data;
        end
    end

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS: csrs = mstatus;
            CSR_MTVEC:   csrs = mtvec;
            CSR_MEPC:    csrs = mepc;
            CSR_MCAUSE:  csrs = mcause;
            default:     csrs = '0;
        endcase
    end

    assign mepc_out  = mepc;
    assign mtvec_out = mtvec;

    // writeback names one csr per instruction.
    a_mask_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(csr_wr.wen));

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                   clock,
    input  wire                   reset,
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::reg_addr_t rs2,
    input  decode_pkg::rf_write_t rf_wr,
    output decode_pkg::word_t     rs1_value,
    output decode_pkg::word_t     rs2_value
);
    import decode_pkg::*;

    word_t regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wr.wen && rf_wr.addr != '0) begin
            regs[rf_wr.addr] <= rf_wr.data;
        end
    end

    // reads see the value before a same-cycle write.
    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];

    a_x0_zero: assert property (@(posedge clock)
        rf_wr.wen |=> (regs[0] == '0));

endmodule

`default_nettype wire

// ==== ctrl_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode (
    input  decode_pkg::word_t inst,
    input  decode_pkg::word_t imm,
    output decode_pkg::ctrl_t ctrl
);
    import decode_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_sys;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign is_sys = (opcode == OP_SYSTEM);

    always_comb begin
        ctrl = '0;

        ctrl.mem_wen = (opcode == OP_STORE);
        ctrl.mem_ren = (opcode == OP_LOAD);
        ctrl.branch  = (opcode == OP_BRANCH);
        ctrl.jump    = (opcode == OP_JAL) || (opcode == OP_JALR);
        ctrl.inv     = (opcode == OP_BRANCH) &&
                       (funct3 == 3'b000 || funct3 == 3'b101 || funct3 == 3'b111);
        ctrl.r_wen   = !(opcode == OP_STORE || opcode == OP_BRANCH || opcode == 7'd0);

        ctrl.csr_wen[0] = is_sys && (imm == word_t'(CSR_MEPC));
        ctrl.csr_wen[1] = is_sys && (imm == word_t'(CSR_MCAUSE));
        ctrl.csr_wen[2] = is_sys && (imm == word_t'(CSR_MSTATUS));
        ctrl.csr_wen[3] = is_sys && (imm == word_t'(CSR_MTVEC));

        ctrl.ecall   = (inst == INST_ECALL);
        ctrl.mret    = (inst == INST_MRET);
        ctrl.fence_i = (inst == INST_FENCE_I);

        if (opcode == OP_LUI) ctrl.add1_sel = SRC1_ZERO;
        else if (opcode == OP_JAL || opcode == OP_AUIPC) ctrl.add1_sel = SRC1_PC;
        else ctrl.add1_sel = SRC1_REG;

        if (opcode == OP_R || opcode == OP_BRANCH) ctrl.add2_sel = SRC2_REG;
        else if (is_sys && funct3 == 3'b010) ctrl.add2_sel = SRC2_CSR_OR;
        else if (is_sys && funct3 == 3'b001) ctrl.add2_sel = SRC2_CSR_WR;
        else ctrl.add2_sel = SRC2_IMM;

        if (opcode == OP_LUI || opcode == OP_AUIPC) ctrl.imm_kind = IMM_20U;
        else if (opcode == OP_JAL) ctrl.imm_kind = IMM_20J;
        else if (opcode == OP_IMM && (funct3 == 3'b001 || funct3 == 3'b101)) begin
            ctrl.imm_kind = IMM_5U; // shamt.
        end else ctrl.imm_kind = IMM_12I;

        ctrl.alu_op = ALU_ADD;
        case (opcode)
            OP_IMM, OP_R: begin
                case (funct3)
                    3'b000: ctrl.alu_op = (opcode == OP_R && funct7 != 7'd0) ? ALU_SUB : ALU_ADD;
                    3'b001: ctrl.alu_op = ALU_SLL;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: ctrl.alu_op = ALU_SLTU;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b101: ctrl.alu_op = (funct7 != 7'd0) ? ALU_SRA : ALU_SRL;
                    3'b110: ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_AND;
                endcase
            end
            OP_BRANCH: begin
                case (funct3[2:1])
                    2'b00: ctrl.alu_op = ALU_EQ;
                    2'b01: ctrl.alu_op = ALU_ADD;
                    2'b10: ctrl.alu_op = ALU_SLT;
                    default: ctrl.alu_op = ALU_SLTU;
                endcase
            end
            OP_SYSTEM: begin
                if (funct3 == 3'b010) ctrl.alu_op = ALU_OR; // csrrs sets bits.
            end
            default: begin
                ctrl.alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  decode_pkg::word_t inst,
    output decode_pkg::word_t imm
);
    import decode_pkg::*;

    opcode_t opcode;

    assign opcode = inst[6:0];

    always_comb begin
        case (opcode)
            OP_R: begin
                imm = {25'd0, inst[31:25]}; // funct7.
            end
            OP_LOAD, OP_IMM, OP_JALR, OP_SYSTEM: begin
                imm = {20'd0, inst[31:20]};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {12'd0, inst[31:12]};
            end
            OP_JAL: begin
                imm = {12'd0, inst[31], inst[19:12], inst[20], inst[30:21]};
            end
            OP_BRANCH: begin
                // sign-extended and already scaled by two.
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OP_STORE: begin
                imm = {20'd0, inst[31:25], inst[11:7]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== decode_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg (
    input  wire               clock,
    input  wire               reset,
    input  wire               valid_last,
    input  wire               ready_next,
    input  wire               inst_clear,
    input  decode_pkg::word_t inst,
    input  decode_pkg::word_t pc,
    output logic              ready_last,
    output logic              valid_next,
    output decode_pkg::word_t inst_q,
    output decode_pkg::word_t pc_q
);

    logic xfer_in;
    logic flush;
    logic flush_pending;

    assign ready_last = ready_next; // no skid buffer.
    assign xfer_in    = valid_last & ready_last;
    assign flush      = inst_clear | flush_pending;

    // a flush seen while idle kills the next accepted instruction.
    always_ff @(posedge clock) begin
        if (reset) begin
            flush_pending <= 1'b0;
        end else if (xfer_in) begin
            flush_pending <= 1'b0;
        end else if (inst_clear) begin
            flush_pending <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_next <= 1'b0;
            inst_q     <= '0;
        end else if (xfer_in) begin
            valid_next <= ~flush;
            inst_q     <= flush ? '0 : inst; // bubble.
        end else if (ready_next) begin
            valid_next <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (xfer_in) pc_q <= pc;
    end

    a_valid_needs_xfer: assert property (@(posedge clock) disable iff (reset)
        $rose(valid_next) |-> $past(xfer_in));

    a_hold_on_stall: assert property (@(posedge clock) disable iff (reset)
        valid_next && !ready_next |=> $stable(inst_q) && $stable(valid_next));

endmodule

`default_nettype wire

// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [3:0]  csr_mask_t; // mepc, mcause, mstatus, mtvec from bit 0.

    // major opcodes.
    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;
    localparam alu_op_t ALU_EQ   = 4'd10;

    localparam logic [1:0] IMM_12I = 2'd0;
    localparam logic [1:0] IMM_5U  = 2'd1;
    localparam logic [1:0] IMM_20U = 2'd2;
    localparam logic [1:0] IMM_20J = 2'd3;

    localparam logic [1:0] SRC1_REG  = 2'd0;
    localparam logic [1:0] SRC1_PC   = 2'd1;
    localparam logic [1:0] SRC1_ZERO = 2'd2;

    localparam logic [1:0] SRC2_IMM    = 2'd0;
    localparam logic [1:0] SRC2_REG    = 2'd1;
    localparam logic [1:0] SRC2_CSR_OR = 2'd2; // csrrs.
    localparam logic [1:0] SRC2_CSR_WR = 2'd3; // csrrw.

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam word_t       MCAUSE_ECALL = 32'd11;

    localparam word_t INST_ECALL   = 32'h0000_0073;
    localparam word_t INST_MRET    = 32'h3020_0073;
    localparam word_t INST_FENCE_I = 32'h0000_100f;

    typedef struct packed {
        logic       mem_wen;
        logic       mem_ren;
        logic [1:0] add1_sel;
        logic [1:0] add2_sel;
        logic       inv;
        logic       branch;
        logic       jump;
        logic [1:0] imm_kind;
        alu_op_t    alu_op;
        logic       r_wen;
        csr_mask_t  csr_wen;
        logic       ecall;
        logic       mret;
        logic       fence_i;
    } ctrl_t;

    typedef struct packed {
        word_t      inst;
        word_t      pc;
        reg_addr_t  rd;
        logic [2:0] funct3;
        word_t      imm;
        ctrl_t      ctrl;
    } decoded_t;

    typedef struct packed {
        logic      wen;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        csr_mask_t wen;
        word_t     data;
    } csr_write_t;

endpackage

`default_nettype wire
